//--- build.f
+incdir+verilog
verilog/trdb_pkg.sv
verilog/trdb_reg_if.sv
verilog/trdb_resync_counter.sv
verilog/trdb_branch_map.sv
verilog/trdb_packet_fsm.sv
verilog/trdb_encoder_top.sv
testbench/tb_trdb_encoder.sv

//--- run_sim.sh
#!/bin/sh
# compile the trace encoder testbench with Verilator, run it, search for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_trdb_encoder -f build.f &&
    ./obj_dir/Vtb_trdb_encoder | tee /dev/stderr | grep "RESULT: PASS" > /dev/null &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

//--- testbench/tb_trdb_encoder.sv
/* trace encoder testbench
   directed tests against a packet reference model, AXI4-Lite config tasks */
`timescale 1ns/1ps
`default_nettype none
`include "trdb_cfg.svh"

module tb_trdb_encoder import trdb_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_INSTR  = 79;     // instructions sent over all tests

    typedef struct packed {
        logic [1:0] fmt;
        bcnt_t      cnt;
        bmap_t      map;
        iaddr_t     addr;
    } pkt_t;

    logic        clk_i, rst_ni;
    logic        s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o, s_bvalid_o, s_bready_i;
    logic [31:0] s_awaddr_i, s_wdata_i, s_araddr_i, s_rdata_o;
    logic [3:0]  s_wstrb_i;
    logic [1:0]  s_bresp_o, s_rresp_o;
    logic        s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
    logic        instr_valid_i, instr_ready_o, instr_branch_i, instr_taken_i;
    iaddr_t      instr_addr_i;
    logic        pkt_valid_o, pkt_ready_i, resync_due_o;
    pkt_fmt_e    pkt_fmt_o;
    bcnt_t       pkt_cnt_o;
    bmap_t       pkt_map_o;
    iaddr_t      pkt_addr_o;

    pkt_t   exp_q[$];           // packets the model predicts, oldest first
    int     err_cnt;
    int     pkt_rx;
    int     seed;
    logic   m_enable;           // model copy of CTRL.enable
    logic   m_idle;             // model in ST_IDLE
    logic   m_due;              // model resync flag
    iaddr_t m_lo, m_hi;
    int     m_cnt;
    bmap_t  m_map;

    trdb_encoder_top dut (.*);

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            err_cnt++;
            $display("Error: %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic push_expected(input logic [1:0] fmt, input bcnt_t cnt, input bmap_t map,
                                 input iaddr_t addr);
        exp_q.push_back({fmt, cnt, map, addr});
    endtask

    // packet rules, applied per accepted instruction
    task automatic model_instr(input iaddr_t addr, input logic br, input logic tk);
        if (!(m_enable && addr >= m_lo && addr <= m_hi)) begin
            m_idle = 1'b1;                              // dropped
        end else if (m_idle || m_due) begin
            push_expected(FMT_SYNC, bcnt_t'(m_cnt), m_map, addr);   // map before this instr
            m_cnt  = 0;
            m_map  = '0;
            m_idle = 1'b0;
            m_due  = 1'b0;
        end else if (br) begin
            m_map[m_cnt] = tk;                          // first branch in bit 0
            m_cnt++;
            if (m_cnt == `TRDB_BMAP_LEN) begin
                push_expected(FMT_BRANCH, bcnt_t'(m_cnt), m_map, addr);
                m_cnt = 0;
                m_map = '0;
            end
        end
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic aw_hs, w_hs;
        int   n;
        s_awvalid_i = 1'b1;
        s_awaddr_i  = addr;
        s_wvalid_i  = 1'b1;
        s_wdata_i   = data;
        s_wstrb_i   = strb;
        n = 0;
        while ((s_awvalid_i || s_wvalid_i) && n < 20) begin
            aw_hs = s_awvalid_i && s_awready_o;         // readies are registered
            w_hs  = s_wvalid_i && s_wready_o;
            @(negedge clk_i);
            if (aw_hs) s_awvalid_i = 1'b0;
            if (w_hs) s_wvalid_i = 1'b0;
            n++;
        end
        while (!s_bvalid_o && n < 20) begin
            @(negedge clk_i);
            n++;
        end
        assert (n < 20) else begin
            err_cnt++;
            $display("AXI write to %h got no write response", addr);
        end
        expect_eq("s_bresp_o", 32'(s_bresp_o), 32'd0);
        @(negedge clk_i);                               // B taken, bready held high
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
        logic ar_hs;
        int   n;
        s_arvalid_i = 1'b1;
        s_araddr_i  = addr;
        n = 0;
        while (s_arvalid_i && n < 20) begin
            ar_hs = s_arready_o;
            @(negedge clk_i);
            if (ar_hs) s_arvalid_i = 1'b0;
            n++;
        end
        while (!s_rvalid_o && n < 20) begin
            @(negedge clk_i);
            n++;
        end
        assert (n < 20) else begin
            err_cnt++;
            $display("AXI read from %h returned no data", addr);
        end
        data = s_rdata_o;
        expect_eq("s_rresp_o", 32'(s_rresp_o), 32'd0);
        @(negedge clk_i);
        s_arvalid_i = 1'b0;
    endtask

    task automatic send_instr(input iaddr_t addr, input logic br, input logic tk);
        logic acc;
        int   n;
        instr_valid_i  = 1'b1;
        instr_addr_i   = addr;
        instr_branch_i = br;
        instr_taken_i  = tk;
        n = 0;
        do begin
            @(posedge clk_i);
            acc = instr_ready_o;                        // value before this edge
            n++;
        end while (!acc && n < 100);
        assert (acc) else begin
            err_cnt++;
            $display("instruction at %h was never accepted", addr);
        end
        if (acc) model_instr(addr, br, tk);
        @(negedge clk_i);
        instr_valid_i = 1'b0;
    endtask

    task automatic send_branches(input int num);
        iaddr_t a;
        logic   t;
        repeat (num) begin
            a = 32'h1000_0000 + (($random(seed) & 32'h3FF) << 2);  // word inside filter
            t = 1'($random(seed));
            send_instr(a, 1'b1, t);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        repeat (2) @(negedge clk_i);
        while (exp_q.size() != 0 && n < 100) begin
            @(negedge clk_i);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            err_cnt++;
            $display("%0d expected packets never arrived by %0t ns", exp_q.size(), $time);
            exp_q.delete();
        end
    endtask

    task automatic compare_packet();
        pkt_t e;
        pkt_rx++;
        assert (exp_q.size() != 0) else begin
            err_cnt++;
            $display("unexpected packet at %0t ns, address %h", $time, pkt_addr_o);
        end
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            expect_eq("pkt_fmt_o", 32'(pkt_fmt_o), 32'(e.fmt));
            expect_eq("pkt_cnt_o", 32'(pkt_cnt_o), 32'(e.cnt));
            expect_eq("pkt_map_o", 32'(pkt_map_o), 32'(e.map));
            expect_eq("pkt_addr_o", pkt_addr_o, e.addr);
        end
    endtask

    // packet handshake seen at the clock edge
    always @(posedge clk_i) begin
        if (rst_ni && pkt_valid_o && pkt_ready_i) begin
            compare_packet();
        end
    end

    task automatic check_registers();
        logic [31:0] rd;
        axi_read(`TRDB_REG_RESYNC, rd);
        expect_eq("s_rdata_o RESYNC", rd, 32'h0000_FFFF);       // reset value
        axi_read(`TRDB_REG_CTRL, rd);
        expect_eq("s_rdata_o CTRL", rd, 32'd0);
        axi_write(`TRDB_REG_CTRL, 32'h3, 4'hF);                 // enable and mode bits
        axi_read(`TRDB_REG_CTRL, rd);
        expect_eq("s_rdata_o CTRL", rd, 32'h3);
        axi_write(`TRDB_REG_CTRL, 32'h0, 4'hF);
        axi_write(`TRDB_REG_RESYNC, 32'hDEAD_1234, 4'hF);
        axi_read(`TRDB_REG_RESYNC, rd);
        expect_eq("s_rdata_o RESYNC", rd, 32'h0000_1234);       // 16-bit limit
        axi_write(`TRDB_REG_RESYNC, 32'h0000_FFFF, 4'hF);
        axi_write(`TRDB_REG_ADDR_LO, 32'h1000_0000, 4'hF);
        axi_read(`TRDB_REG_ADDR_LO, rd);
        expect_eq("s_rdata_o ADDR_LO", rd, 32'h1000_0000);
        axi_write(`TRDB_REG_ADDR_HI, 32'h1000_0FFC, 4'hF);
        axi_write(`TRDB_REG_ADDR_HI, 32'hAABB_CCDD, 4'b0010);   // byte 1 only
        axi_read(`TRDB_REG_ADDR_HI, rd);
        expect_eq("s_rdata_o ADDR_HI", rd, 32'h1000_CCFC);
        axi_write(`TRDB_REG_ADDR_HI, 32'h1000_0FFC, 4'hF);
        axi_read(32'h10, rd);
        expect_eq("s_rdata_o unmapped", rd, 32'd0);
        m_lo = 32'h1000_0000;
        m_hi = 32'h1000_0FFC;
    endtask

    task automatic start_trace();
        axi_write(`TRDB_REG_CTRL, 32'h1, 4'hF);                 // enable, cycle mode
        m_enable = 1'b1;
        for (int i = 0; i < 4; i++) begin
            send_instr(32'h1000_0000 + 32'(4 * i), 1'b0, 1'b0);
        end
        wait_drain();
    endtask

    task automatic fill_branch_map();
        send_branches(31);
        wait_drain();
    endtask

    task automatic filter_range();
        send_branches(3);                               // pending map
        send_instr(32'h2000_0000, 1'b1, 1'b1);          // above ADDR_HI
        send_instr(32'h0FFF_FFFC, 1'b0, 1'b0);          // below ADDR_LO
        wait_drain();
        send_instr(32'h1000_0100, 1'b0, 1'b0);          // back in range
        wait_drain();
    endtask

    task automatic resync_in_packet_mode();
        send_instr(32'h0000_0040, 1'b0, 1'b0);          // idle before the mode change
        axi_write(`TRDB_REG_RESYNC, 32'h2, 4'hF);
        axi_write(`TRDB_REG_CTRL, 32'h3, 4'hF);         // enable, packet mode
        send_instr(32'h1000_0200, 1'b0, 1'b0);
        wait_drain();
        repeat (2) @(negedge clk_i);
        expect_eq("resync_due_o", 32'(resync_due_o), 32'd0);   // one packet so far
        send_branches(31);
        wait_drain();
        repeat (2) @(negedge clk_i);
        expect_eq("resync_due_o", 32'(resync_due_o), 32'd1);
        m_due = 1'b1;
        send_instr(32'h1000_0300, 1'b0, 1'b0);          // resync SYNC
        wait_drain();
        repeat (2) @(negedge clk_i);
        expect_eq("resync_due_o", 32'(resync_due_o), 32'd0);
    endtask

    task automatic stall_output();
        pkt_t held;
        axi_write(`TRDB_REG_RESYNC, 32'h0000_FFFF, 4'hF);
        send_instr(32'h3000_0000, 1'b0, 1'b0);
        pkt_ready_i = 1'b0;
        send_instr(32'h1000_0400, 1'b0, 1'b0);          // SYNC, held at output
        held = {pkt_fmt_o, pkt_cnt_o, pkt_map_o, pkt_addr_o};
        fork
            send_instr(32'h4000_0000, 1'b0, 1'b0);      // waits on the stall
            begin
                repeat (8) begin
                    expect_eq("instr_ready_o", 32'(instr_ready_o), 32'd0);
                    expect_eq("pkt_valid_o", 32'(pkt_valid_o), 32'd1);
                    expect_eq("pkt_fmt_o", 32'(pkt_fmt_o), 32'(held.fmt));
                    expect_eq("pkt_cnt_o", 32'(pkt_cnt_o), 32'(held.cnt));
                    expect_eq("pkt_map_o", 32'(pkt_map_o), 32'(held.map));
                    expect_eq("pkt_addr_o", pkt_addr_o, held.addr);
                    @(negedge clk_i);
                end
                pkt_ready_i = 1'b1;
            end
        join
        send_instr(32'h1000_0404, 1'b1, 1'b1);          // branch on SYNC, bit dropped
        wait_drain();
    endtask

    initial begin
        seed           = 32'h227d;
        err_cnt        = 0;
        pkt_rx         = 0;
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        s_awvalid_i    = 1'b0;
        s_awaddr_i     = '0;
        s_wvalid_i     = 1'b0;
        s_wdata_i      = '0;
        s_wstrb_i      = '0;
        s_bready_i     = 1'b1;
        s_arvalid_i    = 1'b0;
        s_araddr_i     = '0;
        s_rready_i     = 1'b1;
        instr_valid_i  = 1'b0;
        instr_addr_i   = '0;
        instr_branch_i = 1'b0;
        instr_taken_i  = 1'b0;
        pkt_ready_i    = 1'b1;
        m_enable       = 1'b0;
        m_idle         = 1'b1;
        m_due          = 1'b0;
        m_lo           = '0;
        m_hi           = '0;
        m_cnt          = 0;
        m_map          = '0;
        repeat (5) @(negedge clk_i);
        rst_ni = 1'b1;
        expect_eq("pkt_valid_o", 32'(pkt_valid_o), 32'd0);
        expect_eq("instr_ready_o", 32'(instr_ready_o), 32'd1);
        expect_eq("resync_due_o", 32'(resync_due_o), 32'd0);
        expect_eq("s_awready_o", 32'(s_awready_o), 32'd0);
        expect_eq("s_wready_o", 32'(s_wready_o), 32'd0);
        expect_eq("s_bvalid_o", 32'(s_bvalid_o), 32'd0);
        expect_eq("s_arready_o", 32'(s_arready_o), 32'd0);
        expect_eq("s_rvalid_o", 32'(s_rvalid_o), 32'd0);
        check_registers();
        start_trace();
        fill_branch_map();
        filter_range();
        resync_in_packet_mode();
        stall_output();
        repeat (5) @(negedge clk_i);
        $display("%0d errors, %0d packets received", err_cnt, pkt_rx);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // 200 cycles per instruction sent
    initial begin
        #(NUM_INSTR * 200 * CLK_PERIOD);
        $display("watchdog expired at %0t ns, test sequence hung", $time);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/trdb_encoder_top.sv
/* instruction trace encoder top
   AXI4-Lite config, resync counter, branch map and packet FSM */
`timescale 1ns/1ps
`default_nettype none

module trdb_encoder_top import trdb_pkg::*; (
    input  wire         clk_i,
    input  wire         rst_ni,
    // AXI4-Lite config
    input  wire         s_awvalid_i,
    output logic        s_awready_o,
    input  wire  [31:0] s_awaddr_i,
    input  wire         s_wvalid_i,
    output logic        s_wready_o,
    input  wire  [31:0] s_wdata_i,
    input  wire  [3:0]  s_wstrb_i,
    output logic        s_bvalid_o,
    input  wire         s_bready_i,
    output logic [1:0]  s_bresp_o,
    input  wire         s_arvalid_i,
    output logic        s_arready_o,
    input  wire  [31:0] s_araddr_i,
    output logic        s_rvalid_o,
    input  wire         s_rready_i,
    output logic [31:0] s_rdata_o,
    output logic [1:0]  s_rresp_o,
    // instructions
    input  wire         instr_valid_i,
    output logic        instr_ready_o,
    input  wire         iaddr_t instr_addr_i,
    input  wire         instr_branch_i,
    input  wire         instr_taken_i,
    // packets
    output logic        pkt_valid_o,
    input  wire         pkt_ready_i,
    output pkt_fmt_e    pkt_fmt_o,
    output bcnt_t       pkt_cnt_o,
    output bmap_t       pkt_map_o,
    output iaddr_t      pkt_addr_o,
    output logic        resync_due_o
);

    logic         enable;
    resync_mode_e mode;
    resync_cnt_t  resync_max;
    iaddr_t       addr_lo;
    iaddr_t       addr_hi;
    bcnt_t        bmap_cnt;
    bmap_t        bmap_map;
    bmap_t        bmap_merged;
    logic         bmap_full;
    logic         bmap_push;
    logic         bmap_taken;
    logic         bmap_flush;
    logic         resync_clear;
    logic         tracing;
    logic         pkt_accepted;

    trdb_reg_if u_reg_if (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .s_awvalid_i  (s_awvalid_i),
        .s_awready_o  (s_awready_o),
        .s_awaddr_i   (s_awaddr_i),
        .s_wvalid_i   (s_wvalid_i),
        .s_wready_o   (s_wready_o),
        .s_wdata_i    (s_wdata_i),
        .s_wstrb_i    (s_wstrb_i),
        .s_bvalid_o   (s_bvalid_o),
        .s_bready_i   (s_bready_i),
        .s_bresp_o    (s_bresp_o),
        .s_arvalid_i  (s_arvalid_i),
        .s_arready_o  (s_arready_o),
        .s_araddr_i   (s_araddr_i),
        .s_rvalid_o   (s_rvalid_o),
        .s_rready_i   (s_rready_i),
        .s_rdata_o    (s_rdata_o),
        .s_rresp_o    (s_rresp_o),
        .enable_o     (enable),
        .mode_o       (mode),
        .resync_max_o (resync_max),
        .addr_lo_o    (addr_lo),
        .addr_hi_o    (addr_hi)
    );

    trdb_resync_counter u_resync_counter (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .mode_i            (mode),
        .max_i             (resync_max),
        .tracing_i         (tracing),
        .packet_accepted_i (pkt_accepted),
        .clear_i           (resync_clear),
        .resync_due_o      (resync_due_o)
    );

    trdb_branch_map u_branch_map (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (bmap_push),
        .taken_i      (bmap_taken),
        .flush_i      (bmap_flush),
        .cnt_o        (bmap_cnt),
        .map_o        (bmap_map),
        .merged_map_o (bmap_merged),
        .full_o       (bmap_full)
    );

    trdb_packet_fsm u_packet_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_valid_i  (instr_valid_i),
        .instr_addr_i   (instr_addr_i),
        .instr_branch_i (instr_branch_i),
        .instr_taken_i  (instr_taken_i),
        .instr_ready_o  (instr_ready_o),
        .enable_i       (enable),
        .addr_lo_i      (addr_lo),
        .addr_hi_i      (addr_hi),
        .resync_due_i   (resync_due_o),
        .bmap_cnt_i     (bmap_cnt),
        .bmap_map_i     (bmap_map),
        .bmap_merged_i  (bmap_merged),
        .bmap_full_i    (bmap_full),
        .bmap_push_o    (bmap_push),
        .bmap_taken_o   (bmap_taken),
        .bmap_flush_o   (bmap_flush),
        .resync_clear_o (resync_clear),
        .tracing_o      (tracing),
        .pkt_accepted_o (pkt_accepted),
        .pkt_ready_i    (pkt_ready_i),
        .pkt_valid_o    (pkt_valid_o),
        .pkt_fmt_o      (pkt_fmt_o),
        .pkt_cnt_o      (pkt_cnt_o),
        .pkt_map_o      (pkt_map_o),
        .pkt_addr_o     (pkt_addr_o)
    );

endmodule

`default_nettype wire

//--- verilog/trdb_packet_fsm.sv
/* packet FSM
   address filter, start/resync detection, packet choice and output register */
`timescale 1ns/1ps
`default_nettype none
`include "trdb_cfg.svh"

module trdb_packet_fsm import trdb_pkg::*; (
    input  wire      clk_i,
    input  wire      rst_ni,
    // instruction stream
    input  wire      instr_valid_i,
    input  wire      iaddr_t instr_addr_i,
    input  wire      instr_branch_i,
    input  wire      instr_taken_i,
    output logic     instr_ready_o,
    // configuration and resync
    input  wire      enable_i,
    input  wire      iaddr_t addr_lo_i,
    input  wire      iaddr_t addr_hi_i,
    input  wire      resync_due_i,
    // branch map
    input  wire      bcnt_t bmap_cnt_i,
    input  wire      bmap_t bmap_map_i,
    input  wire      bmap_t bmap_merged_i,
    input  wire      bmap_full_i,
    output logic     bmap_push_o,
    output logic     bmap_taken_o,
    output logic     bmap_flush_o,
    output logic     resync_clear_o,
    output logic     tracing_o,
    output logic     pkt_accepted_o,
    // packet out
    input  wire      pkt_ready_i,
    output logic     pkt_valid_o,
    output pkt_fmt_e pkt_fmt_o,
    output bcnt_t    pkt_cnt_o,
    output bmap_t    pkt_map_o,
    output iaddr_t   pkt_addr_o
);

    enc_state_e state_q;
    enc_state_e state_d;
    logic       accept;
    logic       in_range;
    logic       qualified;
    logic       emit_sync;
    logic       emit;

    // one packet in flight, stall only if it is not taken this cycle
    assign instr_ready_o = (state_q != ST_STALL) || pkt_ready_i;
    assign pkt_valid_o   = (state_q == ST_STALL);
    assign tracing_o     = (state_q != ST_IDLE);

    assign accept    = instr_valid_i && instr_ready_o;
    assign in_range  = (instr_addr_i >= addr_lo_i) && (instr_addr_i <= addr_hi_i);
    assign qualified = accept && enable_i && in_range;

    // SYNC first, a branch then is not recorded
    assign emit_sync    = qualified && ((state_q == ST_IDLE) || resync_due_i);
    assign bmap_push_o  = qualified && !emit_sync && instr_branch_i;
    assign bmap_taken_o = instr_taken_i;
    assign bmap_flush_o = emit_sync;
    assign emit         = emit_sync || bmap_full_i;   // full only on a push

    assign resync_clear_o = emit_sync;
    assign pkt_accepted_o = pkt_valid_o && pkt_ready_i;

    always_comb begin
        state_d = state_q;
        if (pkt_accepted_o) begin
            state_d = ST_TRACE;
        end
        if (accept) begin
            if (!qualified) begin
                state_d = ST_IDLE;      // dropped, next qualified syncs
            end else if (emit) begin
                state_d = ST_STALL;
            end else begin
                state_d = ST_TRACE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // output register, emit implies the old packet is gone
    always_ff @(posedge clk_i) begin
        if (emit_sync) begin
            pkt_fmt_o  <= FMT_SYNC;
            pkt_cnt_o  <= bmap_cnt_i;       // map before this instr
            pkt_map_o  <= bmap_map_i;
            pkt_addr_o <= instr_addr_i;
        end else if (bmap_full_i) begin
            pkt_fmt_o  <= FMT_BRANCH;
            pkt_cnt_o  <= bcnt_t'(`TRDB_BMAP_LEN);
            pkt_map_o  <= bmap_merged_i;    // incl. this branch
            pkt_addr_o <= instr_addr_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/trdb_branch_map.sv
/* branch map
   collects taken bits of qualified branches, first branch in bit 0 */
`timescale 1ns/1ps
`default_nettype none
`include "trdb_cfg.svh"

module trdb_branch_map import trdb_pkg::*; (
    input  wire   clk_i,
    input  wire   rst_ni,
    input  wire   push_i,         // qualified branch, no SYNC
    input  wire   taken_i,
    input  wire   flush_i,        // SYNC emitted
    output bcnt_t cnt_o,
    output bmap_t map_o,
    output bmap_t merged_map_o,   // contents incl. current push
    output logic  full_o          // this push fills the map
);

    bcnt_t cnt_q;
    bmap_t map_q;

    assign full_o = push_i && (cnt_q == bcnt_t'(`TRDB_BMAP_LEN - 1));

    always_comb begin
        merged_map_o = map_q;
        if (push_i) begin
            merged_map_o[cnt_q] = taken_i;   // append at index count
        end
    end

    // map bits cleared too, an empty map reads as zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
            map_q <= '0;
        end else if (flush_i || full_o) begin
            cnt_q <= '0;
            map_q <= '0;
        end else if (push_i) begin
            cnt_q <= cnt_q + 1'b1;
            map_q <= merged_map_o;
        end
    end

    assign cnt_o = cnt_q;
    assign map_o = map_q;

endmodule

`default_nettype wire

//--- verilog/trdb_resync_counter.sv
/* resync counter
   counts cycles or packets up to a runtime limit, sticky due flag */
`timescale 1ns/1ps
`default_nettype none

module trdb_resync_counter import trdb_pkg::*; (
    input  wire          clk_i,
    input  wire          rst_ni,
    input  wire          resync_mode_e mode_i,
    input  wire          resync_cnt_t max_i,
    input  wire          tracing_i,          // encoder in ST_TRACE or ST_STALL
    input  wire          packet_accepted_i,
    input  wire          clear_i,            // SYNC emitted
    output logic         resync_due_o
);

    resync_cnt_t cnt_q;
    resync_cnt_t cnt_d;
    logic        cnt_event;

    assign cnt_event = (mode_i == RESYNC_PACKET) ? packet_accepted_i : tracing_i;

    // stops at the limit
    assign cnt_d = (cnt_event && (cnt_q < max_i)) ? cnt_q + 1'b1 : cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q        <= '0;
            resync_due_o <= 1'b0;
        end else if (clear_i) begin                  // clear wins over counting
            cnt_q        <= '0;
            resync_due_o <= 1'b0;
        end else begin
            cnt_q        <= cnt_d;
            resync_due_o <= resync_due_o || (cnt_d >= max_i);   // sticky until clear
        end
    end

endmodule

`default_nettype wire

//--- verilog/trdb_reg_if.sv
/* trace encoder configuration port
   AXI4-Lite slave with control, resync limit and address filter registers */
`timescale 1ns/1ps
`default_nettype none
`include "trdb_cfg.svh"

module trdb_reg_if import trdb_pkg::*; (
    input  wire          clk_i,
    input  wire          rst_ni,
    // write channels
    input  wire          s_awvalid_i,
    output logic         s_awready_o,
    input  wire  [31:0]  s_awaddr_i,
    input  wire          s_wvalid_i,
    output logic         s_wready_o,
    input  wire  [31:0]  s_wdata_i,
    input  wire  [3:0]   s_wstrb_i,
    output logic         s_bvalid_o,
    input  wire          s_bready_i,
    output logic [1:0]   s_bresp_o,
    // read channels
    input  wire          s_arvalid_i,
    output logic         s_arready_o,
    input  wire  [31:0]  s_araddr_i,
    output logic         s_rvalid_o,
    input  wire          s_rready_i,
    output logic [31:0]  s_rdata_o,
    output logic [1:0]   s_rresp_o,
    // configuration out
    output logic         enable_o,
    output resync_mode_e mode_o,
    output resync_cnt_t  resync_max_o,
    output iaddr_t       addr_lo_o,
    output iaddr_t       addr_hi_o
);

    logic         aw_full_q;     // write address held
    logic         w_full_q;      // write data held
    logic [31:0]  aw_addr_q;
    logic [31:0]  w_data_q;
    logic [3:0]   w_strb_q;
    logic [31:0]  wr_merged;     // old value with strobed bytes replaced
    logic         b_hs;

    logic         enable_q;
    resync_mode_e mode_q;
    resync_cnt_t  resync_max_q;
    iaddr_t       addr_lo_q;
    iaddr_t       addr_hi_q;

    function automatic logic [31:0] strb_merge(input logic [31:0] old_v,
                                               input logic [31:0] new_v,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        res = old_v;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_v[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] reg_read(input logic [31:0] addr);
        case (addr)
            `TRDB_REG_CTRL:    return {30'b0, mode_q, enable_q};
            `TRDB_REG_RESYNC:  return 32'(resync_max_q);
            `TRDB_REG_ADDR_LO: return 32'(addr_lo_q);
            `TRDB_REG_ADDR_HI: return 32'(addr_hi_q);
            default:           return '0;     // unmapped reads as zero
        endcase
    endfunction

    assign b_hs      = s_bvalid_o && s_bready_i;
    assign wr_merged = strb_merge(reg_read(aw_addr_q), w_data_q, w_strb_q);

    // AW channel, one-cycle ready pulse then hold until B done
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s_awready_o <= 1'b0;
            aw_full_q   <= 1'b0;
        end else begin
            s_awready_o <= s_awvalid_i && !s_awready_o && !aw_full_q;
            if (s_awvalid_i && s_awready_o) begin
                aw_full_q <= 1'b1;
            end else if (b_hs) begin
                aw_full_q <= 1'b0;
            end
        end
    end

    // W channel, independent of AW
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s_wready_o <= 1'b0;
            w_full_q   <= 1'b0;
        end else begin
            s_wready_o <= s_wvalid_i && !s_wready_o && !w_full_q;
            if (s_wvalid_i && s_wready_o) begin
                w_full_q <= 1'b1;
            end else if (b_hs) begin
                w_full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_awvalid_i && s_awready_o) begin
            aw_addr_q <= s_awaddr_i;
        end
        if (s_wvalid_i && s_wready_o) begin
            w_data_q <= s_wdata_i;
            w_strb_q <= s_wstrb_i;
        end
    end

    // B raised once both halves are in
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s_bvalid_o <= 1'b0;
        end else if (b_hs) begin
            s_bvalid_o <= 1'b0;
        end else if (aw_full_q && w_full_q) begin
            s_bvalid_o <= 1'b1;
        end
    end

    // register update on the B handshake
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q     <= 1'b0;
            mode_q       <= RESYNC_CYCLE;
            resync_max_q <= '1;             // 0xFFFF
            addr_lo_q    <= '0;
            addr_hi_q    <= '0;
        end else if (b_hs) begin
            case (aw_addr_q)
                `TRDB_REG_CTRL: begin
                    enable_q <= wr_merged[0];
                    mode_q   <= resync_mode_e'(wr_merged[1]);
                end
                `TRDB_REG_RESYNC:  resync_max_q <= wr_merged[`TRDB_RESYNC_W-1:0];
                `TRDB_REG_ADDR_LO: addr_lo_q    <= wr_merged[`TRDB_ADDR_W-1:0];
                `TRDB_REG_ADDR_HI: addr_hi_q    <= wr_merged[`TRDB_ADDR_W-1:0];
                default: ;                  // unmapped, dropped
            endcase
        end
    end

    // read path, R one cycle after AR
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s_arready_o <= 1'b0;
            s_rvalid_o  <= 1'b0;
        end else begin
            s_arready_o <= s_arvalid_i && !s_arready_o && !s_rvalid_o;
            if (s_arvalid_i && s_arready_o) begin
                s_rvalid_o <= 1'b1;
            end else if (s_rvalid_o && s_rready_i) begin
                s_rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_arvalid_i && s_arready_o) begin
            s_rdata_o <= reg_read(s_araddr_i);
        end
    end

    assign s_bresp_o    = 2'b00;    // OKAY
    assign s_rresp_o    = 2'b00;    // OKAY
    assign enable_o     = enable_q;
    assign mode_o       = mode_q;
    assign resync_max_o = resync_max_q;
    assign addr_lo_o    = addr_lo_q;
    assign addr_hi_o    = addr_hi_q;

endmodule

`default_nettype wire

//--- verilog/trdb_pkg.sv
/* trace encoder shared types
   vector widths for addresses, counts and maps, plus the encodings */
`default_nettype none
`include "trdb_cfg.svh"

package trdb_pkg;

    typedef logic [`TRDB_ADDR_W-1:0]   iaddr_t;       // instruction address
    typedef logic [`TRDB_RESYNC_W-1:0] resync_cnt_t;  // resync count / limit
    typedef logic [`TRDB_BMAP_LEN-1:0] bmap_t;        // taken bits, first branch in bit 0
    typedef logic [`TRDB_BCNT_W-1:0]   bcnt_t;        // branches in map

    typedef enum logic {
        RESYNC_CYCLE  = 1'b0,   // count cycles while tracing
        RESYNC_PACKET = 1'b1    // count accepted packets
    } resync_mode_e;

    typedef enum logic [1:0] {
        FMT_BRANCH = 2'd1,      // full branch map
        FMT_SYNC   = 2'd3       // start / resync with address
    } pkt_fmt_e;

    typedef enum logic [1:0] {
        ST_IDLE,                // not tracing, next qualified instr syncs
        ST_TRACE,               // tracing, no packet pending
        ST_STALL                // packet waiting on output
    } enc_state_e;

endpackage

`default_nettype wire

//--- verilog/trdb_cfg.svh
/* trace encoder configuration
   data widths and AXI4-Lite register byte offsets */
`ifndef TRDB_CFG_SVH
`define TRDB_CFG_SVH

`define TRDB_ADDR_W      32        // retired instruction address
`define TRDB_RESYNC_W    16        // resync counter and limit
`define TRDB_BMAP_LEN    31        // branches held per map
`define TRDB_BCNT_W      5         // counts 0..31

`define TRDB_REG_CTRL    32'h0     // bit 0 enable, bit 1 mode
`define TRDB_REG_RESYNC  32'h4     // resync limit
`define TRDB_REG_ADDR_LO 32'h8     // filter low bound, inclusive
`define TRDB_REG_ADDR_HI 32'hC     // filter high bound, inclusive

`endif
